// File: project.f
+incdir+dv
hdl/motor_regs_pkg.sv
hdl/bus_decoder.sv
hdl/control_regs.sv
hdl/status_readback.sv
hdl/motor_regs_top.sv
dv/tb_motor_regs.sv

// File: run.sh
#!/bin/sh
# Builds the motor register testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ns -f project.f --top-module tb_motor_regs \
    -o tb_motor_regs > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_motor_regs > sim.log 2>&1 ; cat sim.log

grep -qx "SIMULATION PASSED" sim.log && echo "Run passed" \
    || { echo "Run failed"; exit 1; }

// File: dv/tb_checks.svh
// ~~~~~~~~~~~~~~~~~~~~
// Compare task, bus tasks and directed tests
// ~~~~~~~~~~~~~~~~~~~~
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

task automatic compare_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
        errors++;
        $display("FAILED %0t: %s is %h, expected %h", $time, name, got, exp);
    end
endtask

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
endfunction

// Address map from the base and stride rules
function automatic logic [5:0] drive_reg(input int i, input int off);
    return 6'(4 + 2 * i + off);
endfunction

function automatic logic [5:0] rot_reg(input int j, input int off);
    return 6'(4 + 2 * n_drive + 5 * j + off);   // Rotation block after drives
endfunction

// Returns just after the edge that samples the write
task automatic bus_write(input logic [5:0] addr, input logic [7:0] data);
    @(posedge clock);
    bus.address  <= addr;
    bus.wr_data  <= data;
    bus.write_en <= 1'b1;
    @(posedge clock);
    bus.write_en <= 1'b0;
endtask

task automatic bus_read(input logic [5:0] addr, output logic [7:0] data);
    @(posedge clock);
    bus.address <= addr;
    bus.read_en <= 1'b1;
    @(posedge clock);
    bus.read_en <= 1'b0;
    @(negedge clock);   // Registered, one cycle latency
    data = rd_data;
endtask

// Every control output against the model
task automatic check_controls();
    for (int i = 0; i < n_drive; i++) begin
        compare_value($sformatf("drive_ctrl[%0d] flags", i),
            32'({drive_ctrl[i].brake, drive_ctrl[i].enable, drive_ctrl[i].direction}),
            32'(exp_drive[i][7:5]));
        compare_value($sformatf("drive_ctrl[%0d].pwm", i), 32'(drive_ctrl[i].pwm),
            32'(exp_drive[i][4:0]));
    end
    for (int j = 0; j < n_rot; j++) begin
        compare_value($sformatf("rotation_ctrl[%0d] flags", j),
            32'({rotation_ctrl[j].brake, rotation_ctrl[j].enable,
                 rotation_ctrl[j].direction}),
            32'(exp_rctrl[j][7:5]));
        // Nibble times 256 plus low byte
        compare_value($sformatf("rotation_ctrl[%0d].target_angle", j),
            32'(rotation_ctrl[j].target_angle),
            32'(exp_rctrl[j][3:0]) * 256 + 32'(exp_target[j]));
    end
endtask

task automatic check_pulses(input logic [31:0] exp_update, input logic [31:0] exp_abort);
    compare_value("update_angle", 32'(update_angle), exp_update);
    compare_value("abort_angle", 32'(abort_angle), exp_abort);
endtask

task automatic test_reset_values();
    @(negedge clock);
    check_controls();
    check_pulses(32'd0, 32'd0);
    compare_value("rd_data", 32'(rd_data), 32'd0);
endtask

task automatic test_drive_writes();
    logic [7:0] data;
    for (int i = 0; i < n_drive; i++) begin
        rng = xorshift32(rng);
        bus_write(drive_reg(i, 0), rng[7:0]);
        exp_drive[i] = rng[7:0];
        @(negedge clock);
        check_controls();   // Other motors unchanged too
        bus_read(drive_reg(i, 0), data);
        compare_value($sformatf("drive %0d control readback", i), 32'(data),
            32'(exp_drive[i]));
    end
endtask

task automatic test_broadcasts();
    logic [7:0] data;
    logic [5:0] addr;
    for (int k = 1; k <= 3; k++) begin
        addr = 6'(4 - k);   // 0x03, then 0x02, then 0x01
        rng  = xorshift32(rng);
        bus_write(addr, rng[7:0]);
        for (int i = 0; i < n_drive; i++)
            if (addr != 6'h02) exp_drive[i] = rng[7:0];
        for (int j = 0; j < n_rot; j++)
            if (addr != 6'h03) exp_rctrl[j] = rng[7:0];
        @(negedge clock);
        check_controls();
    end
    for (int j = 0; j < n_rot; j++) begin
        bus_read(rot_reg(j, 2), data);   // Target bytes untouched
        compare_value($sformatf("rotation %0d target readback", j), 32'(data),
            32'(exp_target[j]));
    end
endtask

task automatic test_target_angle();
    logic [7:0] data;
    for (int j = 0; j < n_rot; j++) begin
        rng = xorshift32(rng);
        exp_rctrl[j]  = rng[7:0];
        exp_target[j] = rng[15:8];
        bus_write(rot_reg(j, 0), exp_rctrl[j]);
        bus_write(rot_reg(j, 2), exp_target[j]);
        @(negedge clock);
        check_controls();
        bus_read(rot_reg(j, 0), data);
        compare_value($sformatf("rotation %0d control readback", j), 32'(data),
            32'(exp_rctrl[j]));
        bus_read(rot_reg(j, 2), data);
        compare_value($sformatf("rotation %0d target readback", j), 32'(data),
            32'(exp_target[j]));
    end
endtask

task automatic test_command_pulses();
    logic [7:0] cmd;
    for (int j = 0; j < n_rot; j++) begin
        for (int b = 0; b < 3; b++) begin
            cmd = 8'h00;
            cmd[5] = (b != 1);   // Update
            cmd[4] = (b != 0);   // Abort
            bus_write(rot_reg(j, 4), cmd);
            @(negedge clock);
            check_pulses(cmd[5] ? (32'd1 << j) : 32'd0, cmd[4] ? (32'd1 << j) : 32'd0);
            @(negedge clock);
            check_pulses(32'd0, 32'd0);   // Gone after one cycle
        end
    end
    // Broadcasts load control bytes and give no pulse
    for (int k = 1; k <= 3; k++) begin
        bus_write(6'(k), 8'h30);
        for (int i = 0; i < n_drive; i++)
            if (k != 2) exp_drive[i] = 8'h30;
        for (int j = 0; j < n_rot; j++)
            if (k != 3) exp_rctrl[j] = 8'h30;
        @(negedge clock);
        check_pulses(32'd0, 32'd0);
        check_controls();
    end
endtask

task automatic test_status_readback();
    logic [8:0]  st [n_drive + n_rot];   // Drive motors first
    logic [12:0] fb [n_rot];
    logic [7:0]  data;
    logic [5:0]  addr;
    for (int m = 0; m < n_drive + n_rot; m++) begin
        rng   = xorshift32(rng);
        st[m] = rng[8:0];
    end
    for (int j = 0; j < n_rot; j++) begin
        rng   = xorshift32(rng);
        fb[j] = rng[12:0];
    end
    @(posedge clock);
    for (int i = 0; i < n_drive; i++)
        drive_status[i] <= motor_regs_pkg::motor_status_t'(st[i]);
    for (int j = 0; j < n_rot; j++) begin
        rotation_status[j]   <= motor_regs_pkg::motor_status_t'(st[n_drive + j]);
        rotation_feedback[j] <= motor_regs_pkg::angle_feedback_t'(fb[j]);
    end
    repeat (2) @(posedge clock);   // Stable before any read
    for (int m = 0; m < n_drive + n_rot; m++) begin
        addr = (m < n_drive) ? drive_reg(m, 1) : rot_reg(m - n_drive, 1);
        bus_read(addr, data);
        // Fault, startup failure, temperature 5..0
        compare_value($sformatf("status byte of motor %0d", m), 32'(data),
            32'({st[m][8], st[m][7], st[m][5:0]}));
    end
    for (int j = 0; j < n_rot; j++) begin
        bus_read(rot_reg(j, 3), data);
        compare_value($sformatf("angle low of rotation %0d", j), 32'(data),
            32'(fb[j][7:0]));
        bus_read(rot_reg(j, 4), data);   // Done flag over angle 11..8
        compare_value($sformatf("angle high of rotation %0d", j), 32'(data),
            32'({fb[j][12], 3'b000, fb[j][11:8]}));
    end
endtask

// Registers hold data by now, so a stale or aliased read shows up
task automatic test_unmapped_reads();
    logic [7:0] data;
    logic [5:0] addr;
    for (int u = 0; u < 2; u++) begin
        bus_read(drive_reg(0, 0), data);   // Nonzero since the last broadcast
        compare_value("drive 0 control readback", 32'(data), 32'(exp_drive[0]));
        addr = (u == 0) ? 6'h00 : 6'h3F;   // Below and above the map
        bus_read(addr, data);
        compare_value($sformatf("rd_data at 0x%h", addr), 32'(data), 32'd0);
    end
endtask

`endif

// File: dv/tb_motor_regs.sv
// ~~~~~~~~~~~~~~~~~~~~
// Motor register block testbench
// Clock, reset, DUT and directed test sequence
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tb_motor_regs;

    localparam int n_drive = 4;
    localparam int n_rot   = 4;
    // Rough cycles per test: reset, drive, broadcast, angle, command, status, unmapped
    localparam int test_cycles = 10 + 40 + 40 + 50 + 60 + 60 + 20;
    localparam int cycle_limit = 2 * test_cycles;

    logic                                        clock;
    logic                                        rst_n;
    motor_regs_pkg::reg_bus_t                    bus;
    motor_regs_pkg::motor_status_t [n_drive-1:0] drive_status;
    motor_regs_pkg::motor_status_t [n_rot-1:0]   rotation_status;
    motor_regs_pkg::angle_feedback_t [n_rot-1:0] rotation_feedback;
    motor_regs_pkg::reg_data_t                   rd_data;
    motor_regs_pkg::drive_ctrl_t [n_drive-1:0]   drive_ctrl;
    motor_regs_pkg::rotation_ctrl_t [n_rot-1:0]  rotation_ctrl;
    logic [n_rot-1:0]                            update_angle;
    logic [n_rot-1:0]                            abort_angle;

    int          errors = 0;
    int          cycles = 0;
    logic [31:0] rng    = 32'h145d_b03d;   // xorshift state

    // Reference model of the control registers
    logic [7:0] exp_drive  [n_drive] = '{default: 8'h00};
    logic [7:0] exp_rctrl  [n_rot]   = '{default: 8'h00};
    logic [7:0] exp_target [n_rot]   = '{default: 8'h00};

    motor_regs_top #(
        .num_drive         (n_drive),
        .num_rotation      (n_rot)
    ) i_dut (
        .clock             (clock),
        .rst_n             (rst_n),
        .bus               (bus),
        .drive_status      (drive_status),
        .rotation_status   (rotation_status),
        .rotation_feedback (rotation_feedback),
        .rd_data           (rd_data),
        .drive_ctrl        (drive_ctrl),
        .rotation_ctrl     (rotation_ctrl),
        .update_angle      (update_angle),
        .abort_angle       (abort_angle)
    );

    `include "tb_checks.svh"

    // 40 ns period
    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Ends a hung run at the cycle limit
    initial begin : watchdog
        while (cycles < cycle_limit) begin
            @(posedge clock);
            cycles++;
        end
        $display("Timeout after %0d cycles, the tests did not finish", cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst_n             = 1'b0;   // Held for 3 cycles
        bus               = '0;
        drive_status      = '0;
        rotation_status   = '0;
        rotation_feedback = '0;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;

        test_reset_values();
        test_drive_writes();
        test_broadcasts();
        test_target_angle();
        test_command_pulses();
        test_status_readback();
        test_unmapped_reads();

        $display("Tests finished with %0d errors", errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/motor_regs_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Swerve motor register block
// Decoder, control bank and status readback
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module motor_regs_top #(
    parameter int num_drive    = 4,   // Drive motors
    parameter int num_rotation = 4    // Rotation motors
) (
    input  wire                                                  clock,
    input  wire                                                  rst_n,
    input  wire motor_regs_pkg::reg_bus_t                        bus,
    input  wire motor_regs_pkg::motor_status_t [num_drive-1:0]   drive_status,
    input  wire motor_regs_pkg::motor_status_t [num_rotation-1:0] rotation_status,
    input  wire motor_regs_pkg::angle_feedback_t [num_rotation-1:0] rotation_feedback,
    output motor_regs_pkg::reg_data_t                            rd_data,
    output motor_regs_pkg::drive_ctrl_t [num_drive-1:0]          drive_ctrl,
    output motor_regs_pkg::rotation_ctrl_t [num_rotation-1:0]    rotation_ctrl,
    output logic [num_rotation-1:0]                              update_angle,
    output logic [num_rotation-1:0]                              abort_angle
);

    localparam int num_motor = num_drive + num_rotation;

    // Write strobes from the decoder
    logic [num_drive-1:0]      drive_ctrl_we;
    logic [num_rotation-1:0]   rotation_ctrl_we;
    logic [num_rotation-1:0]   rotation_target_we;
    motor_regs_pkg::reg_data_t wr_byte;

    // Stored bytes for readback
    motor_regs_pkg::reg_data_t [num_motor-1:0]    ctrl_bytes;
    motor_regs_pkg::reg_data_t [num_rotation-1:0] target_bytes;

    bus_decoder #(
        .num_drive          (num_drive),
        .num_rotation       (num_rotation)
    ) i_bus_decoder (
        .clock              (clock),
        .rst_n              (rst_n),
        .bus                (bus),
        .drive_ctrl_we      (drive_ctrl_we),
        .rotation_ctrl_we   (rotation_ctrl_we),
        .rotation_target_we (rotation_target_we),
        .wr_byte            (wr_byte),
        .update_angle       (update_angle),
        .abort_angle        (abort_angle)
    );

    control_regs #(
        .num_drive          (num_drive),
        .num_rotation       (num_rotation)
    ) i_control_regs (
        .clock              (clock),
        .rst_n              (rst_n),
        .drive_ctrl_we      (drive_ctrl_we),
        .rotation_ctrl_we   (rotation_ctrl_we),
        .rotation_target_we (rotation_target_we),
        .wr_byte            (wr_byte),
        .drive_ctrl         (drive_ctrl),
        .rotation_ctrl      (rotation_ctrl),
        .ctrl_bytes         (ctrl_bytes),
        .target_bytes       (target_bytes)
    );

    status_readback #(
        .num_drive          (num_drive),
        .num_rotation       (num_rotation)
    ) i_status_readback (
        .clock              (clock),
        .rst_n              (rst_n),
        .bus                (bus),
        .drive_status       (drive_status),
        .rotation_status    (rotation_status),
        .rotation_feedback  (rotation_feedback),
        .ctrl_bytes         (ctrl_bytes),
        .target_bytes       (target_bytes),
        .rd_data            (rd_data)
    );

endmodule

`default_nettype wire

// File: hdl/status_readback.sv
// ~~~~~~~~~~~~~~~~~~~~
// Status capture and readback
// Samples motor feedback, registers the read mux
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module status_readback #(
    parameter int num_drive    = 4,
    parameter int num_rotation = 4
) (
    input  wire                                                  clock,
    input  wire                                                  rst_n,
    input  wire motor_regs_pkg::reg_bus_t                        bus,
    input  wire motor_regs_pkg::motor_status_t [num_drive-1:0]   drive_status,
    input  wire motor_regs_pkg::motor_status_t [num_rotation-1:0] rotation_status,
    input  wire motor_regs_pkg::angle_feedback_t [num_rotation-1:0] rotation_feedback,
    input  wire motor_regs_pkg::reg_data_t [num_drive+num_rotation-1:0] ctrl_bytes,
    input  wire motor_regs_pkg::reg_data_t [num_rotation-1:0]    target_bytes,
    output motor_regs_pkg::reg_data_t                            rd_data
);

    localparam int num_motor = num_drive + num_rotation;

    motor_regs_pkg::reg_data_t [num_motor-1:0]    status_q;    // Drive motors first
    motor_regs_pkg::reg_data_t [num_rotation-1:0] angle_lo_q;  // Current angle 7..0
    motor_regs_pkg::reg_data_t [num_rotation-1:0] angle_hi_q;  // Done flag and 11..8
    motor_regs_pkg::reg_data_t                    rd_next;

    // Fault in bit 7, startup failure in bit 6, low temperature bits below
    function automatic motor_regs_pkg::reg_data_t status_byte(
        input motor_regs_pkg::motor_status_t s
    );
        return {s.fault, s.startup_fail, s.adc_temp[5:0]};
    endfunction

    // Free-running capture of the motor side
    always_ff @(posedge clock) begin
        for (int i = 0; i < num_drive; i++) begin
            status_q[i] <= status_byte(drive_status[i]);
        end
        for (int j = 0; j < num_rotation; j++) begin
            status_q[num_drive + j] <= status_byte(rotation_status[j]);
            angle_lo_q[j] <= rotation_feedback[j].current_angle[7:0];
            angle_hi_q[j] <= {rotation_feedback[j].angle_done, 3'b000,
                              rotation_feedback[j].current_angle[11:8]};
        end
    end

    // Read mux, unmapped and write-only addresses give zero
    always_comb begin
        rd_next = '0;
        for (int i = 0; i < num_drive; i++) begin
            if (bus.address == motor_regs_pkg::drive_addr(i, motor_regs_pkg::drive_off_ctrl))
                rd_next = ctrl_bytes[i];
            if (bus.address == motor_regs_pkg::drive_addr(i, motor_regs_pkg::drive_off_status))
                rd_next = status_q[i];
        end
        for (int j = 0; j < num_rotation; j++) begin
            if (bus.address == motor_regs_pkg::rotation_addr(
                    num_drive, j, motor_regs_pkg::rot_off_ctrl))
                rd_next = ctrl_bytes[num_drive + j];
            if (bus.address == motor_regs_pkg::rotation_addr(
                    num_drive, j, motor_regs_pkg::rot_off_status))
                rd_next = status_q[num_drive + j];
            if (bus.address == motor_regs_pkg::rotation_addr(
                    num_drive, j, motor_regs_pkg::rot_off_target))
                rd_next = target_bytes[j];
            if (bus.address == motor_regs_pkg::rotation_addr(
                    num_drive, j, motor_regs_pkg::rot_off_angle_lo))
                rd_next = angle_lo_q[j];
            // Command address reads back the angle high byte
            if (bus.address == motor_regs_pkg::rotation_addr(
                    num_drive, j, motor_regs_pkg::rot_off_cmd))
                rd_next = angle_hi_q[j];
        end
    end

    // Loads only on a read strobe, holds otherwise
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (bus.read_en) begin
            rd_data <= rd_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/control_regs.sv
// ~~~~~~~~~~~~~~~~~~~~
// Motor control register bank
// Stores control and target bytes, unpacks them per motor
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module control_regs #(
    parameter int num_drive    = 4,
    parameter int num_rotation = 4
) (
    input  wire                                               clock,
    input  wire                                               rst_n,
    input  wire [num_drive-1:0]                               drive_ctrl_we,
    input  wire [num_rotation-1:0]                            rotation_ctrl_we,
    input  wire [num_rotation-1:0]                            rotation_target_we,
    input  wire motor_regs_pkg::reg_data_t                    wr_byte,
    output motor_regs_pkg::drive_ctrl_t [num_drive-1:0]       drive_ctrl,
    output motor_regs_pkg::rotation_ctrl_t [num_rotation-1:0] rotation_ctrl,
    output motor_regs_pkg::reg_data_t [num_drive+num_rotation-1:0] ctrl_bytes,
    output motor_regs_pkg::reg_data_t [num_rotation-1:0]      target_bytes
);

    localparam int num_motor = num_drive + num_rotation;

    logic [num_motor-1:0] ctrl_we;  // Drive motors in the low bits

    assign ctrl_we = {rotation_ctrl_we, drive_ctrl_we};

    // Control bytes, one per motor
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_bytes <= '0;
        end else begin
            for (int m = 0; m < num_motor; m++) begin
                if (ctrl_we[m]) begin
                    ctrl_bytes[m] <= wr_byte;  // Several at once on broadcast
                end
            end
        end
    end

    // Target angle low bytes
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            target_bytes <= '0;
        end else begin
            for (int j = 0; j < num_rotation; j++) begin
                if (rotation_target_we[j]) begin
                    target_bytes[j] <= wr_byte;
                end
            end
        end
    end

    // Drive byte already matches the struct bit order
    always_comb begin
        for (int i = 0; i < num_drive; i++) begin
            drive_ctrl[i] = motor_regs_pkg::drive_ctrl_t'(ctrl_bytes[i]);
        end
    end

    // Rotation control
    // Bit 4 of the control byte is stored and read back but drives nothing
    always_comb begin
        for (int j = 0; j < num_rotation; j++) begin
            rotation_ctrl[j].brake     = ctrl_bytes[num_drive + j][7];
            rotation_ctrl[j].enable    = ctrl_bytes[num_drive + j][6];
            rotation_ctrl[j].direction = ctrl_bytes[num_drive + j][5];
            // High nibble lives in the control byte
            rotation_ctrl[j].target_angle = {ctrl_bytes[num_drive + j][3:0],
                                             target_bytes[j]};
        end
    end

endmodule

`default_nettype wire

// File: hdl/bus_decoder.sv
// ~~~~~~~~~~~~~~~~~~~~
// Host bus write decoder
// Per-register strobes and command pulses
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module bus_decoder #(
    parameter int num_drive    = 4,
    parameter int num_rotation = 4
) (
    input  wire                           clock,
    input  wire                           rst_n,
    input  wire motor_regs_pkg::reg_bus_t bus,
    output logic [num_drive-1:0]          drive_ctrl_we,      // Drive control byte
    output logic [num_rotation-1:0]       rotation_ctrl_we,   // Rotation control byte
    output logic [num_rotation-1:0]       rotation_target_we, // Target angle low byte
    output motor_regs_pkg::reg_data_t     wr_byte,
    output logic [num_rotation-1:0]       update_angle,       // One-cycle pulse
    output logic [num_rotation-1:0]       abort_angle         // One-cycle pulse
);

    logic                    bcast_drive;     // Broadcast that reaches drive motors
    logic                    bcast_rotation;  // Broadcast that reaches rotation motors
    logic [num_rotation-1:0] cmd_hit;         // Write to a command address

    // 0x01 hits everyone, 0x03 only drive motors
    assign bcast_drive = (bus.address == motor_regs_pkg::addr_bcast_all)
                      || (bus.address == motor_regs_pkg::addr_bcast_drive);
    // 0x02 only rotation motors
    assign bcast_rotation = (bus.address == motor_regs_pkg::addr_bcast_all)
                         || (bus.address == motor_regs_pkg::addr_bcast_rotation);

    assign wr_byte = bus.wr_data;  // Same byte goes to every strobed register

    // Drive control strobes
    always_comb begin
        for (int i = 0; i < num_drive; i++) begin
            drive_ctrl_we[i] = bus.write_en
                && (bcast_drive
                    || bus.address == motor_regs_pkg::drive_addr(
                           i, motor_regs_pkg::drive_off_ctrl));
        end
    end

    // Rotation strobes, broadcasts only touch control bytes
    always_comb begin
        for (int j = 0; j < num_rotation; j++) begin
            rotation_ctrl_we[j] = bus.write_en
                && (bcast_rotation
                    || bus.address == motor_regs_pkg::rotation_addr(
                           num_drive, j, motor_regs_pkg::rot_off_ctrl));
            rotation_target_we[j] = bus.write_en
                && bus.address == motor_regs_pkg::rotation_addr(
                       num_drive, j, motor_regs_pkg::rot_off_target);
            cmd_hit[j] = bus.write_en
                && bus.address == motor_regs_pkg::rotation_addr(
                       num_drive, j, motor_regs_pkg::rot_off_cmd);
        end
    end

    // Command bits turn into pulses the cycle after the write
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            update_angle <= '0;
            abort_angle  <= '0;
        end else begin
            // Only the addressed motor, both bits may fire together
            update_angle <= cmd_hit
                          & {num_rotation{bus.wr_data[motor_regs_pkg::cmd_update_bit]}};
            abort_angle  <= cmd_hit
                          & {num_rotation{bus.wr_data[motor_regs_pkg::cmd_abort_bit]}};
        end
    end

endmodule

`default_nettype wire

// File: hdl/motor_regs_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Motor register block shared definitions
// Bus layout, address map and motor control structs
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package motor_regs_pkg;

    typedef logic [5:0]  reg_addr_t;   // Host bus address
    typedef logic [7:0]  reg_data_t;   // One register byte
    typedef logic [4:0]  pwm_t;        // Drive PWM level
    typedef logic [11:0] angle_t;      // Rotation angle
    typedef logic [6:0]  adc_temp_t;   // Raw ADC temperature

    // Host bus, plain strobes and no handshake
    typedef struct packed {
        reg_addr_t address;
        logic      write_en;
        reg_data_t wr_data;
        logic      read_en;
    } reg_bus_t;

    typedef struct packed {
        logic brake;       // Bit 7
        logic enable;      // Bit 6
        logic direction;   // Bit 5
        pwm_t pwm;         // Bits 4..0
    } drive_ctrl_t;

    typedef struct packed {
        logic   brake;
        logic   enable;
        logic   direction;
        angle_t target_angle;  // High nibble from control, low byte from target reg
    } rotation_ctrl_t;

    typedef struct packed {
        logic      fault;
        logic      startup_fail;
        adc_temp_t adc_temp;   // Only bits 5..0 reach the status byte
    } motor_status_t;

    typedef struct packed {
        logic   angle_done;
        angle_t current_angle;
    } angle_feedback_t;

    // Broadcast addresses
    localparam reg_addr_t addr_bcast_all      = 6'h01;
    localparam reg_addr_t addr_bcast_rotation = 6'h02;
    localparam reg_addr_t addr_bcast_drive    = 6'h03;

    localparam reg_addr_t drive_base      = 6'h04;
    localparam reg_addr_t drive_stride    = 6'd2;
    localparam reg_addr_t rotation_stride = 6'd5;

    localparam int drive_off_ctrl   = 0;
    localparam int drive_off_status = 1;
    localparam int rot_off_ctrl     = 0;
    localparam int rot_off_status   = 1;
    localparam int rot_off_target   = 2;   // Target angle low byte
    localparam int rot_off_angle_lo = 3;   // Current angle low byte
    localparam int rot_off_cmd      = 4;   // Command on write, angle high on read

    localparam logic [2:0] cmd_abort_bit  = 3'd4;
    localparam logic [2:0] cmd_update_bit = 3'd5;

    // Rotation block sits right after the last drive motor
    function automatic reg_addr_t rotation_base(input int n_drive);
        return reg_addr_t'(int'(drive_base) + int'(drive_stride) * n_drive);
    endfunction

    function automatic reg_addr_t drive_addr(input int idx, input int offset);
        return reg_addr_t'(int'(drive_base) + int'(drive_stride) * idx + offset);
    endfunction

    function automatic reg_addr_t rotation_addr(input int n_drive, input int idx,
                                                input int offset);
        return reg_addr_t'(int'(rotation_base(n_drive)) + int'(rotation_stride) * idx
                           + offset);
    endfunction

endpackage

`default_nettype wire
